//--- filelist.f
cpu_fe_pkg.sv
unified_mem.sv
mem_arbiter.sv
branch_predictor.sv
fetch_unit.sv
if_id_pipe_reg.sv
branch_resolver.sv
cpu_front_end.sv
fe_checker.sv
tb_cpu_front_end.sv

//--- Bender.yml
package:
  name: cpu_front_end

sources:
  - cpu_fe_pkg.sv
  - unified_mem.sv
  - mem_arbiter.sv
  - branch_predictor.sv
  - fetch_unit.sv
  - if_id_pipe_reg.sv
  - branch_resolver.sv
  - cpu_front_end.sv
  - target: test
    files:
      - fe_checker.sv
      - tb_cpu_front_end.sv

//--- tb_cpu_front_end.sv
`timescale 1ns/1ns

module tb_cpu_front_end;
  import cpu_fe_pkg::*;

  localparam int mem_aw  = 8;
  localparam int pred_iw = 3;

  // Rough cycle cost per test, reset and loading included
  localparam int len_data    = 60;
  localparam int len_line    = 70;
  localparam int len_stall   = 20;
  localparam int len_first   = 40;
  localparam int len_loop    = 40;
  localparam int len_random  = 360;
  localparam int cycle_limit =
    4 * (len_data + len_line + len_stall + len_first + len_loop + len_random);
  localparam int rand_cycles = 300;

  logic       clk;
  logic       arst_n;
  logic       d_req;
  logic       d_we;
  word_t      d_addr;
  word_t      d_wdata;
  word_t      d_rdata;
  logic [2:0] flags;
  word_t      id_pc_curr;
  word_t      id_inst;
  pred_t      id_prediction;
  word_t      id_predicted_target;
  logic       redirect;

  word_t prog [64];  // Image for load_program
  int    seed;
  int    rnd;
  int    cycles;
  word_t held_pc;

  cpu_front_end #(.mem_aw(mem_aw), .pred_iw(pred_iw)) dut0 (.*);

  fe_checker #(.mem_aw(mem_aw), .pred_iw(pred_iw)) chk0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hard stop if some wait never ends
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped: cycle limit %0d reached", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  ///////////////////////////////
  // Stimulus helpers
  ///////////////////////////////
  function automatic word_t fill_word(input word_t a);
    return (a * 16'h9e37) ^ 16'h3c5a;  // Every address bit matters
  endfunction

  function automatic word_t br_word(input int cond, input int off);
    return {op_br, cond[2:0], off[8:0]};
  endfunction

  function automatic word_t alu_word(input int r);
    return {op_add, r[3:0], ~r[3:0], r[3:0] ^ 4'h5};
  endfunction

  task automatic clear_prog();
    for (int i = 0; i < 64; i++) begin
      prog[i] = '0;
    end
  endtask

  // Data port keeps the memory at release, so fetch waits
  task automatic apply_reset();
    arst_n  = 1'b0;
    d_req   = 1'b1;
    d_we    = 1'b0;
    d_addr  = '0;
    d_wdata = '0;
    flags   = '0;
    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
  endtask

  task automatic mem_write(input word_t a, input word_t w);
    d_req   = 1'b1;
    d_we    = 1'b1;
    d_addr  = a;
    d_wdata = w;
    @(posedge clk);
    #1;
  endtask

  task automatic mem_read(input word_t a, input word_t exp);
    d_req  = 1'b1;
    d_we   = 1'b0;
    d_addr = a;
    #1 chk0.check("d_rdata", exp, d_rdata);  // Same-cycle read data
    @(posedge clk);
    #1;
  endtask

  task automatic load_program(input int n);
    apply_reset();
    for (int i = 0; i < n; i++) begin
      mem_write(i, prog[i]);
    end
    d_req = 1'b0;  // Fetch starts at pc 0
    d_we  = 1'b0;
  endtask

  task automatic wait_branch(input int max);
    inst_u u;
    logic  hit;
    hit = 1'b0;
    for (int n = 0; (n < max) && !hit; n++) begin
      @(posedge clk);
      #1;
      u   = id_inst;
      hit = (u.br.opcode == op_br);
    end
    if (!hit) chk0.note_error("no branch reached decode in time");
  endtask

  task automatic wait_redirect(input int max);
    logic hit;
    hit = 1'b0;
    for (int n = 0; (n < max) && !hit; n++) begin
      @(posedge clk);
      #1;
      hit = redirect;
    end
    if (!hit) chk0.note_error("redirect never rose");
  endtask

  ///////////////////////////////
  // Tests
  ///////////////////////////////
  initial begin
    seed = 32'h9ccf6978;
    apply_reset();
    for (int i = 0; i < 16; i++) begin
      mem_write(16'h00a0 + i, fill_word(16'h00a0 + i));
    end
    for (int i = 0; i < 16; i++) begin
      mem_read(16'h00a0 + i, fill_word(16'h00a0 + i));
    end
    chk0.end_test("data port write and read");

    clear_prog();
    for (int i = 0; i < 30; i++) begin
      prog[i] = (i % 3 == 0) ? '0 : alu_word(i);  // No-ops mixed in
    end
    load_program(30);
    for (int k = 0; k < 24; k++) begin
      @(posedge clk);
      #1;
      chk0.check("id_pc_curr", k, id_pc_curr);
      chk0.check("id_inst", prog[k], id_inst);
    end
    chk0.end_test("straight line fetch");

    while (id_inst != '0) begin  // Stall only over a no-op
      @(posedge clk);
      #1;
    end
    held_pc = id_pc_curr;
    d_req   = 1'b1;
    d_addr  = 16'd5;
    repeat (5) begin
      @(posedge clk);
      #1;
      chk0.check("id_pc_curr", held_pc, id_pc_curr);
      chk0.check("id_inst", '0, id_inst);
    end
    d_req = 1'b0;
    @(posedge clk);
    #1;
    chk0.check("id_pc_curr", held_pc + 16'd1, id_pc_curr);
    chk0.check("id_inst", prog[held_pc + 16'd1], id_inst);
    chk0.end_test("data port stall");

    clear_prog();
    prog[4]  = br_word(1, 5);  // 4+1+5 lands on 10
    prog[5]  = alu_word(3);    // Wrong path
    prog[10] = alu_word(2);
    load_program(12);
    flags = 3'b001;
    wait_redirect(20);
    chk0.check("id_pc_curr", 16'd4, id_pc_curr);
    @(posedge clk);
    #1;
    chk0.check("id_inst", '0, id_inst);  // Flushed bubble
    @(posedge clk);
    #1;
    chk0.check("id_pc_curr", 16'd10, id_pc_curr);
    chk0.check("id_inst", prog[10], id_inst);
    chk0.end_test("first taken branch");

    clear_prog();
    prog[4] = alu_word(7);
    prog[5] = br_word(1, -2);  // Loop back to 4
    load_program(6);
    flags = 3'b001;
    wait_branch(20);  // Cold miss, redirect
    wait_branch(20);  // Counter 2, BTB hit
    wait_branch(20);
    chk0.check("id_prediction", 2'd3, id_prediction);
    chk0.check("id_predicted_target", 16'd4, id_predicted_target);
    chk0.check("redirect", 1'b0, redirect);
    wait_branch(20);
    flags = 3'b000;  // Loop exit
    #1 chk0.check("redirect", 1'b1, redirect);
    @(posedge clk);
    #1;
    chk0.check("id_inst", '0, id_inst);
    @(posedge clk);
    #1;
    chk0.check("id_pc_curr", 16'd6, id_pc_curr);
    chk0.end_test("trained loop branch");

    clear_prog();
    for (int i = 0; i < 40; i++) begin
      if (i >= 32) prog[i] = br_word(7, -(i + 1));  // Back to 0
      else if (i % 2 == 0) prog[i] = br_word((i % 7) + 1, ((i * 5 + 3) % 32) - (i + 1));
      else prog[i] = alu_word(i);
    end
    load_program(40);
    repeat (rand_cycles) begin
      rnd   = $random(seed);
      flags = rnd[2:0];
      @(posedge clk);
      #1;
    end
    chk0.end_test("random flags");

    chk0.report_totals();
    if (chk0.total_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- fe_checker.sv
`timescale 1ns/1ns

module fe_checker #(
  parameter int mem_aw  = 8,
  parameter int pred_iw = 3
) (
  input logic                          clk,
  input logic                          arst_n,
  input logic                          d_req,
  input logic                          d_we,
  input cpu_fe_pkg::word_t             d_addr,
  input cpu_fe_pkg::word_t             d_wdata,
  input cpu_fe_pkg::word_t             d_rdata,
  input logic [cpu_fe_pkg::cond_w-1:0] flags,
  input cpu_fe_pkg::word_t             id_pc_curr,
  input cpu_fe_pkg::word_t             id_inst,
  input cpu_fe_pkg::pred_t             id_prediction,
  input cpu_fe_pkg::word_t             id_predicted_target,
  input logic                          redirect
);
  import cpu_fe_pkg::*;

  localparam int depth   = 2**mem_aw;
  localparam int entries = 2**pred_iw;

  // Reference state, memory tracked from data port writes
  word_t mem [depth];
  pred_t ctr [entries];
  logic  vld [entries];
  word_t tag [entries];  // Whole branch PC, upper bits compared
  word_t tgt [entries];

  word_t pc;      // Expected fetch PC
  word_t e_pc;    // Expected IF/ID contents
  word_t e_next;
  word_t e_inst;
  pred_t e_pred;
  word_t e_tgt;

  word_t f_inst;  // Per-edge scratch
  pred_t f_ctr;
  word_t f_tgt;
  word_t f_next;
  word_t fix_pc;
  logic  mis;
  int    slot;

  int errs       = 0;  // Running test only
  int total_errs = 0;
  int tests      = 0;
  int passed     = 0;

  ///////////////////////////////
  // Reference rules
  ///////////////////////////////
  function automatic logic is_branch(input word_t w);
    inst_u u;
    u = w;
    return u.br.opcode == op_br;
  endfunction

  function automatic logic br_taken(input word_t w, input logic [2:0] f);
    inst_u u;
    u = w;
    return is_branch(w) && ((u.br.cond & f) != 3'b000);  // Any common bit
  endfunction

  // Path the branch really takes, PC+1 for anything else
  function automatic word_t correct_pc(input word_t p, input word_t w, input logic [2:0] f);
    inst_u u;
    int    off;
    u   = w;
    off = $signed(u.br.offset);
    if (br_taken(w, f)) begin
      return word_t'(p + 1 + off);
    end
    return p + 16'd1;
  endfunction

  function automatic logic btb_hit(input word_t p);
    int i;
    i = p % entries;
    return vld[i] && ((tag[i] >> pred_iw) == (p >> pred_iw));
  endfunction

  function automatic word_t predict_pc(input word_t p);
    if (btb_hit(p) && (ctr[p % entries] >= 2)) begin
      return tgt[p % entries];  // Hit and leaning taken
    end
    return p + 16'd1;
  endfunction

  ///////////////////////////////
  // Model, one step per edge
  ///////////////////////////////
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] = '0;
      end
      for (int i = 0; i < entries; i++) begin
        ctr[i] = 2'd1;  // Weakly not taken
        vld[i] = 1'b0;
      end
      pc     = '0;
      e_pc   = '0;
      e_next = '0;
      e_inst = '0;
      e_pred = '0;
      e_tgt  = '0;
    end else begin
      // Fetch lookup sees the tables before training
      f_inst = mem[pc % depth];
      f_ctr  = ctr[pc % entries];
      f_tgt  = btb_hit(pc) ? tgt[pc % entries] : '0;
      f_next = predict_pc(pc);
      fix_pc = correct_pc(e_pc, e_inst, flags);
      mis    = is_branch(e_inst) && (fix_pc != e_next);
      if (is_branch(e_inst)) begin
        slot = e_pc % entries;
        if (br_taken(e_inst, flags)) begin
          ctr[slot] = (ctr[slot] == 2'd3) ? 2'd3 : ctr[slot] + 2'd1;
          vld[slot] = 1'b1;
          tag[slot] = e_pc;
          tgt[slot] = fix_pc;
        end else begin
          ctr[slot] = (ctr[slot] == 2'd0) ? 2'd0 : ctr[slot] - 2'd1;
        end
      end
      if (!d_req) begin  // PCs in IF/ID ignore flush
        e_pc   = pc;
        e_next = f_next;
      end
      if (mis) begin
        e_inst = '0;
        e_pred = '0;
        e_tgt  = '0;
        pc     = fix_pc;
      end else if (!d_req) begin
        e_inst = f_inst;
        e_pred = f_ctr;
        e_tgt  = f_tgt;
        pc     = f_next;
      end
      if (d_req && d_we) begin
        mem[d_addr % depth] = d_wdata;
      end
    end
  end

  ///////////////////////////////
  // Compare and report
  ///////////////////////////////
  task automatic check(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      errs++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errs++;
  endtask

  // Mid-cycle, all outputs settled
  always @(negedge clk) begin
    if (arst_n) begin
      check("id_pc_curr", e_pc, id_pc_curr);
      check("id_inst", e_inst, id_inst);
      check("id_prediction", e_pred, id_prediction);
      check("id_predicted_target", e_tgt, id_predicted_target);
      check("redirect", is_branch(e_inst) && (correct_pc(e_pc, e_inst, flags) != e_next),
            redirect);
      if (d_req && !d_we) begin
        check("d_rdata", mem[d_addr % depth], d_rdata);
      end
    end
  end

  task automatic end_test(input string name);
    tests++;
    total_errs += errs;
    if (errs == 0) begin
      passed++;
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errs);
    end
    errs = 0;
  endtask

  task automatic report_totals();
    $display("summary: %0d tests, %0d passed, %0d errors", tests, passed, total_errs);
  endtask

endmodule

//--- cpu_front_end.sv
`timescale 1ns/1ns

module cpu_front_end #(
  parameter int mem_aw  = 8,
  parameter int pred_iw = 3
) (
  input  logic                          clk,
  input  logic                          arst_n,
  // External data port
  input  logic                          d_req,
  input  logic                          d_we,
  input  cpu_fe_pkg::word_t             d_addr,
  input  cpu_fe_pkg::word_t             d_wdata,
  output cpu_fe_pkg::word_t             d_rdata,
  input  logic [cpu_fe_pkg::cond_w-1:0] flags,        // Branch condition inputs
  // Decode stage view
  output cpu_fe_pkg::word_t             id_pc_curr,
  output cpu_fe_pkg::word_t             id_inst,
  output cpu_fe_pkg::pred_t             id_prediction,
  output cpu_fe_pkg::word_t             id_predicted_target,
  output logic                          redirect
);
  import cpu_fe_pkg::*;

  // Memory side
  logic [mem_aw-1:0] m_addr;
  logic              m_we;
  word_t             m_wdata;
  word_t             m_rdata;

  // Fetch and prediction
  logic  fetch_gnt;
  word_t pc;
  word_t pc_next;
  word_t inst;
  pred_t pred_ctr;
  logic  pred_hit;
  word_t pred_target;

  // Decode and training
  word_t id_pc_next;
  word_t redirect_pc;
  logic  upd_en;
  word_t upd_pc;
  logic  upd_taken;
  word_t upd_target;

  ///////////////////////////////
  // Memory and arbitration
  ///////////////////////////////
  unified_mem #(.mem_aw(mem_aw)) u_mem (
    .clk, .arst_n, .addr(m_addr), .we(m_we), .wdata(m_wdata), .rdata(m_rdata)
  );

  mem_arbiter #(.mem_aw(mem_aw)) u_arb (
    .clk, .arst_n, .d_req, .d_we, .d_addr, .d_wdata, .d_rdata,
    .f_addr(pc), .f_inst(inst), .fetch_gnt,
    .m_addr, .m_we, .m_wdata, .m_rdata
  );

  ///////////////////////////////
  // Fetch stage
  ///////////////////////////////
  branch_predictor #(.pred_iw(pred_iw)) u_bp (
    .clk, .arst_n, .look_pc(pc), .pred_ctr, .pred_hit, .pred_target,
    .upd_en, .upd_pc, .upd_taken, .upd_target
  );

  fetch_unit u_fetch (
    .clk, .arst_n, .fetch_gnt, .redirect, .redirect_pc,
    .pred_ctr, .pred_hit, .pred_target, .pc, .pc_next
  );

  // Stalled whenever the data port holds the memory
  if_id_pipe_reg u_if_id (
    .clk, .arst_n, .stall(~fetch_gnt), .flush(redirect),
    .pc_curr(pc), .pc_next, .inst, .prediction(pred_ctr),
    .predicted_target(pred_target),
    .id_pc_curr, .id_pc_next, .id_inst, .id_prediction, .id_predicted_target
  );

  ///////////////////////////////
  // Decode stage
  ///////////////////////////////
  branch_resolver u_res (
    .clk, .arst_n, .id_pc_curr, .id_pc_next, .id_inst, .flags,
    .redirect, .redirect_pc, .upd_en, .upd_pc, .upd_taken, .upd_target
  );

endmodule

//--- branch_resolver.sv
`timescale 1ns/1ns

module branch_resolver (
  input  logic                          clk,
  input  logic                          arst_n,
  input  cpu_fe_pkg::word_t             id_pc_curr,
  input  cpu_fe_pkg::word_t             id_pc_next,   // Path fetch actually took
  input  cpu_fe_pkg::word_t             id_inst,
  input  logic [cpu_fe_pkg::cond_w-1:0] flags,
  output logic                          redirect,
  output cpu_fe_pkg::word_t             redirect_pc,
  output logic                          upd_en,
  output cpu_fe_pkg::word_t             upd_pc,
  output logic                          upd_taken,
  output cpu_fe_pkg::word_t             upd_target
);
  import cpu_fe_pkg::*;

  inst_u ir;          // Decoded view of the ID word
  logic  is_br;
  logic  taken;
  word_t pc_plus1;
  word_t offset_sx;   // Sign extended offset
  word_t br_target;
  word_t correct_pc;

  assign ir = id_inst;

  ///////////////////////////////
  // Branch decode
  ///////////////////////////////
  assign is_br     = (ir.br.opcode == op_br);
  assign taken     = is_br && |(ir.br.cond & flags);  // Any shared flag bit
  assign pc_plus1  = id_pc_curr + 1'b1;
  assign offset_sx = {{(word_w-off_w){ir.br.offset[off_w-1]}}, ir.br.offset};
  assign br_target = pc_plus1 + offset_sx;

  assign correct_pc = taken ? br_target : pc_plus1;

  // Mismatch against what fetch guessed
  assign redirect    = is_br && (correct_pc != id_pc_next);
  assign redirect_pc = correct_pc;

  // Every branch trains, right or wrong
  assign upd_en     = is_br;
  assign upd_pc     = id_pc_curr;
  assign upd_taken  = taken;
  assign upd_target = br_target;

  // A redirect trains now and leaves a flushed bubble in ID next cycle
  a_redirect_bubble: assert property (
    @(posedge clk) disable iff (!arst_n)
    redirect |-> upd_en ##1 !upd_en
  ) else $error("branch_resolver: redirect without training or bubble");

endmodule

//--- if_id_pipe_reg.sv
`timescale 1ns/1ns

module if_id_pipe_reg (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              stall,               // Hold everything
  input  logic              flush,               // Kill the fetched instruction
  input  cpu_fe_pkg::word_t pc_curr,
  input  cpu_fe_pkg::word_t pc_next,
  input  cpu_fe_pkg::word_t inst,
  input  cpu_fe_pkg::pred_t prediction,
  input  cpu_fe_pkg::word_t predicted_target,
  output cpu_fe_pkg::word_t id_pc_curr,
  output cpu_fe_pkg::word_t id_pc_next,
  output cpu_fe_pkg::word_t id_inst,
  output cpu_fe_pkg::pred_t id_prediction,
  output cpu_fe_pkg::word_t id_predicted_target
);
  import cpu_fe_pkg::*;

  logic wen;  // Register write enable

  assign wen = ~stall;

  ///////////////////////////////
  // PC fields, not cleared by flush
  ///////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_pc_curr <= '0;
      id_pc_next <= '0;
    end else if (wen) begin
      id_pc_curr <= pc_curr;
      id_pc_next <= pc_next;
    end
  end

  ///////////////////////////////
  // Flushable fields
  ///////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_inst             <= nop_word;
      id_prediction       <= '0;
      id_predicted_target <= '0;
    end else if (flush) begin
      // Bubble into decode, overrides a stall
      id_inst             <= nop_word;
      id_prediction       <= '0;
      id_predicted_target <= '0;
    end else if (wen) begin
      id_inst             <= inst;
      id_prediction       <= prediction;
      id_predicted_target <= predicted_target;
    end
  end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              fetch_gnt,    // Memory granted to fetch this cycle
  input  logic              redirect,     // Mispredict from decode
  input  cpu_fe_pkg::word_t redirect_pc,
  input  cpu_fe_pkg::pred_t pred_ctr,
  input  logic              pred_hit,
  input  cpu_fe_pkg::word_t pred_target,
  output cpu_fe_pkg::word_t pc,
  output cpu_fe_pkg::word_t pc_next       // Predicted next PC, also sent to IF/ID
);

  logic use_pred;  // BTB hit with a taken-leaning counter

  ///////////////////////////////
  // Next PC selection
  ///////////////////////////////
  assign use_pred = pred_hit && pred_ctr[1];
  assign pc_next  = use_pred ? pred_target : pc + 1'b1;

  // Redirect wins over back-pressure
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (fetch_gnt) begin
      pc <= pc_next;
    end
  end

endmodule

//--- branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor #(
  parameter int pred_iw = 3
) (
  input  logic              clk,
  input  logic              arst_n,
  // Lookup from fetch
  input  cpu_fe_pkg::word_t look_pc,
  output cpu_fe_pkg::pred_t pred_ctr,
  output logic              pred_hit,
  output cpu_fe_pkg::word_t pred_target,
  // Training from the resolver
  input  logic              upd_en,
  input  cpu_fe_pkg::word_t upd_pc,
  input  logic              upd_taken,
  input  cpu_fe_pkg::word_t upd_target
);
  import cpu_fe_pkg::*;

  localparam int entries = 2**pred_iw;
  localparam int tag_w   = word_w - pred_iw;  // PC bits above the index

  pred_t              ctr_tbl [entries];  // Direction counters
  logic [entries-1:0] btb_vld;
  logic [tag_w-1:0]   btb_tag [entries];
  word_t              btb_tgt [entries];

  logic [pred_iw-1:0] look_idx;
  logic [tag_w-1:0]   look_tag;
  logic [pred_iw-1:0] upd_idx;
  logic [tag_w-1:0]   upd_tag;
  pred_t              upd_ctr;  // Counter being trained

  ///////////////////////////////
  // Lookup
  ///////////////////////////////
  assign look_idx = look_pc[pred_iw-1:0];
  assign look_tag = look_pc[word_w-1:pred_iw];

  assign pred_ctr    = ctr_tbl[look_idx];  // Counter read even on BTB miss
  assign pred_hit    = btb_vld[look_idx] && (btb_tag[look_idx] == look_tag);
  assign pred_target = pred_hit ? btb_tgt[look_idx] : '0;

  ///////////////////////////////
  // Update
  ///////////////////////////////
  assign upd_idx = upd_pc[pred_iw-1:0];
  assign upd_tag = upd_pc[word_w-1:pred_iw];
  assign upd_ctr = ctr_tbl[upd_idx];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < entries; i++) begin
        ctr_tbl[i] <= ctr_init;
      end
      btb_vld <= '0;
    end else if (upd_en) begin
      // One step toward the outcome, saturating at both ends
      if (upd_taken && (upd_ctr != 2'd3)) begin
        ctr_tbl[upd_idx] <= upd_ctr + 2'd1;
      end else if (!upd_taken && (upd_ctr != 2'd0)) begin
        ctr_tbl[upd_idx] <= upd_ctr - 2'd1;
      end
      if (upd_taken) begin
        btb_vld[upd_idx] <= 1'b1;  // Entry becomes live on first taken
      end
    end
  end

  // Tag and target only matter once the valid bit is set
  always_ff @(posedge clk) begin
    if (upd_en && upd_taken) begin
      btb_tag[upd_idx] <= upd_tag;
      btb_tgt[upd_idx] <= upd_target;
    end
  end

  // An unknown update PC would corrupt an unknown table entry
  a_upd_pc_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    upd_en |-> !$isunknown(upd_pc)
  ) else $error("branch_predictor: update with unknown pc");

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter #(
  parameter int mem_aw = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  // Data port, highest priority
  input  logic              d_req,
  input  logic              d_we,
  input  cpu_fe_pkg::word_t d_addr,
  input  cpu_fe_pkg::word_t d_wdata,
  output cpu_fe_pkg::word_t d_rdata,
  // Fetch port
  input  cpu_fe_pkg::word_t f_addr,
  output cpu_fe_pkg::word_t f_inst,
  output logic              fetch_gnt,
  // Memory side
  output logic [mem_aw-1:0] m_addr,
  output logic              m_we,
  output cpu_fe_pkg::word_t m_wdata,
  input  cpu_fe_pkg::word_t m_rdata
);

  ///////////////////////////////
  // Fixed priority select
  ///////////////////////////////
  assign fetch_gnt = ~d_req;  // Fetch only runs when data is idle

  always_comb begin
    if (d_req) begin
      m_addr = d_addr[mem_aw-1:0];  // Upper address bits ignored
      m_we   = d_we;
    end else begin
      m_addr = f_addr[mem_aw-1:0];
      m_we   = 1'b0;                // Fetch never writes
    end
  end

  assign m_wdata = d_wdata;  // Only meaningful with m_we

  // Same read word goes to both, each side knows when it owns it
  assign d_rdata = m_rdata;
  assign f_inst  = m_rdata;

  // A write strobe only counts under the data request, otherwise it is lost
  a_we_with_req: assert property (
    @(posedge clk) disable iff (!arst_n)
    d_we |-> d_req
  ) else $error("mem_arbiter: write strobe without data request");

endmodule

//--- unified_mem.sv
`timescale 1ns/1ns

module unified_mem #(
  parameter int mem_aw = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [mem_aw-1:0] addr,
  input  logic              we,
  input  cpu_fe_pkg::word_t wdata,
  output cpu_fe_pkg::word_t rdata
);
  import cpu_fe_pkg::*;

  localparam int depth = 2**mem_aw;

  word_t mem [depth];  // Shared instruction and data store

  // Read path has no latency, fetch sees the word in the same cycle
  assign rdata = mem[addr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;  // Empty memory decodes as no-ops
      end
    end else if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Writes only come from the data port, so the address must be clean
  a_we_addr_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    we |-> !$isunknown(addr)
  ) else $error("unified_mem: write with unknown address");

endmodule

//--- cpu_fe_pkg.sv
package cpu_fe_pkg;

  ///////////////////////////////
  // Widths
  ///////////////////////////////
  localparam int word_w = 16;  // Machine word, address and data
  localparam int op_w   = 4;   // Opcode field
  localparam int reg_w  = 4;   // Register specifier
  localparam int cond_w = 3;   // Branch condition mask, matches flags
  localparam int off_w  = 9;   // Signed branch offset

  typedef logic [word_w-1:0] word_t;
  typedef logic [1:0]        pred_t;  // 2-bit saturating counter

  localparam pred_t ctr_init = 2'd1;  // Weakly not taken

  ///////////////////////////////
  // Opcodes
  ///////////////////////////////
  localparam logic [op_w-1:0] op_nop = 4'd0;
  localparam logic [op_w-1:0] op_add = 4'd1;
  localparam logic [op_w-1:0] op_sub = 4'd2;
  localparam logic [op_w-1:0] op_br  = 4'd12;

  // All-zero word, loaded on flush and reset
  localparam word_t nop_word = {op_nop, {(word_w-op_w){1'b0}}};

  // One instruction word, two decodes
  typedef union packed {
    struct packed {
      logic [op_w-1:0]  opcode;
      logic [reg_w-1:0] rd;
      logic [reg_w-1:0] rs;
      logic [reg_w-1:0] rt;
    } alu;
    struct packed {
      logic [op_w-1:0]   opcode;
      logic [cond_w-1:0] cond;    // Taken if any bit matches flags
      logic [off_w-1:0]  offset;  // Relative to PC+1
    } br;
  } inst_u;

endpackage
